//--- bus_pkg.sv
// bus slave subsystem shared types
// word and field types, state encoding and the constants that set
// the register map, watchdog length and status word layout

`default_nettype none

package bus_pkg;

  // bus word and command fields
  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_addr_t;

  localparam int NUM_REGS = 8;
  localparam int ADDR_LSB = 24;

  // host wait timer
  typedef logic [6:0] wait_count_t;

  localparam int WATCHDOG_LIMIT = 64;

  // completed transaction counter
  typedef logic [15:0] txn_count_t;

  // status word layout
  localparam int STAT_ADDR_ERROR   = 0;
  localparam int STAT_WRITE_DONE   = 1;
  localparam int STAT_TIMEOUT_SEEN = 2;
  localparam int STAT_ADDR_LSB     = 4;
  localparam int STAT_COUNT_LSB    = 16;

  // command phase, data word phase, status word phase
  typedef enum logic [4:0] {
    S_RW0, S_RW1, S_RW2, S_RW3, S_RW4, S_RW5, S_RW6,
    S_WWD0, S_WWD1, S_WWD2, S_WWD3, S_WWD4,
    S_WWS0, S_WWS1, S_WWS2, S_WWS3, S_WWS4
  } fsm_state_t;

endpackage

`default_nettype wire

//--- bus_ctrl_if.sv
// bus slave control strobes
// one-cycle pulses from the state machine that tell the register bank
// and the reply formatter when to act

`timescale 1ns/1ps
`default_nettype none

interface bus_ctrl_if;

  logic load_cmd;
  logic commit_write;
  logic send_data;
  logic send_status;

  modport fsm (
    output load_cmd,
    output commit_write,
    output send_data,
    output send_status
  );

  modport bank (
    input load_cmd,
    input commit_write
  );

  // load_cmd is only watched by the formatter's protocol check
  modport reply (
    input load_cmd,
    input commit_write,
    input send_data,
    input send_status
  );

endinterface

`default_nettype wire

//--- bus_fsm.sv
// bus slave sequencer
// Moore FSM that takes a command word, then returns a data word and a
// status word, each over a four-phase handshake with the host

`timescale 1ns/1ps
`default_nettype none

module bus_fsm import bus_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       subsystem_enable,
  input  logic       rw,
  input  logic       handshake_1,
  input  logic       timeout,
  output logic       handshake_2,
  output logic       waiting,
  bus_ctrl_if.fsm    ctrl
);

  fsm_state_t state;
  fsm_state_t next_state;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= S_RW0;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    unique case (state)
      // command phase
      S_RW0: begin
        // a host still holding handshake_1 after an abort must let go first
        if (subsystem_enable && !handshake_1) begin
          next_state = S_RW1;
        end
      end
      S_RW1: begin
        if (handshake_1) begin
          next_state = S_RW2;
        end
      end
      S_RW2: begin
        next_state = rw ? S_RW3 : S_RW4;
      end
      S_RW3: begin
        next_state = S_RW4;
      end
      S_RW4: begin
        next_state = S_RW5;
      end
      S_RW5: begin
        if (timeout) begin
          next_state = S_RW0;
        end else if (!handshake_1) begin
          next_state = S_RW6;
        end
      end
      S_RW6: begin
        next_state = S_WWD0;
      end
      // data word phase
      S_WWD0: begin
        next_state = S_WWD1;
      end
      S_WWD1: begin
        next_state = S_WWD2;
      end
      S_WWD2: begin
        if (timeout) begin
          next_state = S_RW0;
        end else if (handshake_1) begin
          next_state = S_WWD3;
        end
      end
      S_WWD3: begin
        next_state = S_WWD4;
      end
      S_WWD4: begin
        if (timeout) begin
          next_state = S_RW0;
        end else if (!handshake_1) begin
          next_state = S_WWS0;
        end
      end
      // status word phase
      S_WWS0: begin
        next_state = S_WWS1;
      end
      S_WWS1: begin
        next_state = S_WWS2;
      end
      S_WWS2: begin
        if (timeout) begin
          next_state = S_RW0;
        end else if (handshake_1) begin
          next_state = S_WWS3;
        end
      end
      S_WWS3: begin
        next_state = S_WWS4;
      end
      S_WWS4: begin
        if (timeout || !handshake_1) begin
          next_state = S_RW0;
        end
      end
      default: begin
        next_state = S_RW0;
      end
    endcase
  end

  // moore outputs
  assign ctrl.load_cmd     = (state == S_RW2);
  assign ctrl.commit_write = (state == S_RW3);
  assign ctrl.send_data    = (state == S_WWD0);
  assign ctrl.send_status  = (state == S_WWS0);

  assign handshake_2 = (state == S_RW3)  || (state == S_RW4)  ||
                       (state == S_WWD1) || (state == S_WWD2) ||
                       (state == S_WWS1) || (state == S_WWS2);

  // states where progress depends on the host
  assign waiting = (state == S_RW5)  || (state == S_WWD2) || (state == S_WWD4) ||
                   (state == S_WWS2) || (state == S_WWS4);

  a_one_strobe: assert property (
    @(posedge clk) disable iff (!reset)
    $onehot0({ctrl.load_cmd, ctrl.commit_write, ctrl.send_data, ctrl.send_status})
  ) else $error("bus_fsm: more than one control strobe active");

endmodule

`default_nettype wire

//--- handshake_watchdog.sv
// handshake watchdog
// counts consecutive cycles spent waiting on the host and pulses
// timeout when the host stalls too long

`timescale 1ns/1ps
`default_nettype none

module handshake_watchdog import bus_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic waiting,
  output logic timeout
);

  wait_count_t wait_count;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wait_count <= '0;
    end else if (!waiting || timeout) begin
      // restart after any break in the wait or after firing
      wait_count <= '0;
    end else begin
      wait_count <= wait_count + 1'b1;
    end
  end

  // fires on the cycle after the limit of wait cycles has been counted
  assign timeout = waiting && (wait_count == wait_count_t'(WATCHDOG_LIMIT));

  a_timeout_after_full_wait: assert property (
    @(posedge clk) disable iff (!reset)
    $rose(timeout) |-> waiting && $past(waiting, WATCHDOG_LIMIT)
  ) else $error("handshake_watchdog: timeout without a full wait");

endmodule

`default_nettype wire

//--- register_bank.sv
// register bank
// latches the command word, holds eight 32-bit registers and commits
// writes to valid addresses; addresses past the bank read as zero

`timescale 1ns/1ps
`default_nettype none

module register_bank import bus_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  word_t      bus_in,
  bus_ctrl_if.bank   ctrl,
  output word_t      reg_data,
  output reg_addr_t  addr,
  output logic       addr_error
);

  localparam int INDEX_WIDTH = $clog2(NUM_REGS);

  reg_addr_t                cmd_addr;
  logic [ADDR_LSB-1:0]      cmd_data;
  logic [INDEX_WIDTH-1:0]   reg_index;
  word_t                    regs [NUM_REGS];

  // command fields held for the rest of the transaction
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      cmd_addr <= '0;
    end else if (ctrl.load_cmd) begin
      cmd_addr <= bus_in[ADDR_LSB +: $bits(reg_addr_t)];
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load_cmd) begin
      cmd_data <= bus_in[ADDR_LSB-1:0];
    end
  end

  assign addr_error = (cmd_addr >= reg_addr_t'(NUM_REGS));
  assign reg_index  = cmd_addr[INDEX_WIDTH-1:0];

  // registers come up as zero
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.commit_write && !addr_error) begin
      regs[reg_index] <= word_t'(cmd_data);
    end
  end

  // read is after the write commit, so it shows the updated content
  assign reg_data = addr_error ? '0 : regs[reg_index];
  assign addr     = cmd_addr;

  a_commit_after_load: assert property (
    @(posedge clk) disable iff (!reset)
    ctrl.commit_write |-> $past(ctrl.load_cmd)
  ) else $error("register_bank: write commit without a fresh command");

endmodule

`default_nettype wire

//--- reply_formatter.sv
// reply formatter
// drives bus_out with the data word and then the status word, and keeps
// the transaction count and the sticky write and timeout flags

`timescale 1ns/1ps
`default_nettype none

module reply_formatter import bus_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  bus_ctrl_if.reply  ctrl,
  input  word_t      reg_data,
  input  reg_addr_t  addr,
  input  logic       addr_error,
  input  logic       timeout,
  output word_t      bus_out
);

  txn_count_t txn_count;
  txn_count_t txn_count_next;
  logic       write_done;
  logic       timeout_seen;
  word_t      status_word;

  assign txn_count_next = txn_count + 1'b1;

  // write and abort history up to the next status word
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      write_done   <= 1'b0;
      timeout_seen <= 1'b0;
    end else begin
      if (ctrl.send_status) begin
        write_done   <= 1'b0;
        timeout_seen <= 1'b0;
      end
      // a committed write survives an abort
      if (ctrl.commit_write && !addr_error) begin
        write_done <= 1'b1;
      end
      if (timeout) begin
        timeout_seen <= 1'b1;
      end
    end
  end

  always_comb begin
    status_word = '0;
    status_word[STAT_ADDR_ERROR]   = addr_error;
    status_word[STAT_WRITE_DONE]   = write_done;
    status_word[STAT_TIMEOUT_SEEN] = timeout_seen;
    status_word[STAT_ADDR_LSB +: $bits(reg_addr_t)]  = addr;
    // count includes the transaction being reported
    status_word[STAT_COUNT_LSB +: $bits(txn_count_t)] = txn_count_next;
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      txn_count <= '0;
      bus_out   <= '0;
    end else if (ctrl.send_data) begin
      bus_out <= reg_data;
    end else if (ctrl.send_status) begin
      bus_out   <= status_word;
      txn_count <= txn_count_next;
    end
  end

  a_status_before_next_cmd: assert property (
    @(posedge clk) disable iff (!reset)
    ctrl.send_data |=> !ctrl.load_cmd until (ctrl.send_status || timeout)
  ) else $error("reply_formatter: new command before the status word");

endmodule

`default_nettype wire

//--- bus_subsystem.sv
// bus slave subsystem top level
// joins the sequencer, watchdog, register bank and reply formatter
// behind the host's two-wire handshake

`timescale 1ns/1ps
`default_nettype none

module bus_subsystem import bus_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  subsystem_enable,
  input  logic  rw,
  input  logic  handshake_1,
  input  word_t bus_in,
  output logic  handshake_2,
  output word_t bus_out
);

  logic      waiting;
  logic      timeout;
  word_t     reg_data;
  reg_addr_t addr;
  logic      addr_error;

  bus_ctrl_if ctrl ();

  bus_fsm i_bus_fsm (
    .clk              (clk),
    .reset            (reset),
    .subsystem_enable (subsystem_enable),
    .rw               (rw),
    .handshake_1      (handshake_1),
    .timeout          (timeout),
    .handshake_2      (handshake_2),
    .waiting          (waiting),
    .ctrl             (ctrl.fsm)
  );

  handshake_watchdog i_handshake_watchdog (
    .clk     (clk),
    .reset   (reset),
    .waiting (waiting),
    .timeout (timeout)
  );

  register_bank i_register_bank (
    .clk        (clk),
    .reset      (reset),
    .bus_in     (bus_in),
    .ctrl       (ctrl.bank),
    .reg_data   (reg_data),
    .addr       (addr),
    .addr_error (addr_error)
  );

  reply_formatter i_reply_formatter (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl.reply),
    .reg_data   (reg_data),
    .addr       (addr),
    .addr_error (addr_error),
    .timeout    (timeout),
    .bus_out    (bus_out)
  );

endmodule

`default_nettype wire

//--- tb_bus_subsystem.sv
// testbench for the bus slave subsystem
// table-driven host model with random handshake delays, checked against
// a reference model of the registers and the transaction count

`timescale 1ns/1ps
`default_nettype none

module tb_bus_subsystem
  import bus_pkg::*;
();

  localparam int NUM_ROWS       = 16;
  localparam int ABORT_HOLD     = 80;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 200 + 500;

  typedef struct packed {
    logic                rw;
    reg_addr_t           addr;
    logic [ADDR_LSB-1:0] wdata;
    logic                abort;
    word_t               exp_data;
    word_t               exp_status;
  } row_t;

  logic        clk;
  logic        reset;
  logic        subsystem_enable;
  logic        rw;
  logic        handshake_1;
  word_t       bus_in;
  logic        handshake_2;
  word_t       bus_out;
  row_t        rows [NUM_ROWS];
  int          row_count;
  int          cycle_count;
  logic [31:0] lfsr_state;

  bus_subsystem i_bus_subsystem (
    .clk              (clk),
    .reset            (reset),
    .subsystem_enable (subsystem_enable),
    .rw               (rw),
    .handshake_1      (handshake_1),
    .bus_in           (bus_in),
    .handshake_2      (handshake_2),
    .bus_out          (bus_out)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: host handshake did not finish within %0d cycles", cycle_count);
      $display("=== FAIL ===");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // 0 to 3 idle cycles from two fresh lfsr bits
  task automatic host_delay;
    int cycles;
    cycles = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      cycles     = cycles * 2 + int'(lfsr_state[0]);
    end
    repeat (cycles) @(negedge clk);
  endtask

  task automatic check_value(input string name, input word_t actual,
                             input word_t expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic wait_for_handshake_2(input logic level);
    @(negedge clk);
    while (handshake_2 !== level) begin
      @(negedge clk);
    end
  endtask

  task automatic add_row(input logic row_rw, input int row_addr,
                         input logic [ADDR_LSB-1:0] row_wdata, input logic row_abort);
    rows[row_count].rw         = row_rw;
    rows[row_count].addr       = reg_addr_t'(row_addr);
    rows[row_count].wdata      = row_wdata;
    rows[row_count].abort      = row_abort;
    rows[row_count].exp_data   = '0;
    rows[row_count].exp_status = '0;
    row_count = row_count + 1;
  endtask

  // walks the table in order and fills in the expected data and status words
  task automatic compute_expected;
    word_t      model_regs [NUM_REGS];
    txn_count_t model_count;
    logic       write_pending;
    logic       timeout_pending;
    logic       valid;
    word_t      status;
    model_count     = '0;
    write_pending   = 1'b0;
    timeout_pending = 1'b0;
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      valid = (rows[i].addr < NUM_REGS);
      // a write commits right after the command, even if the row aborts later
      if (rows[i].rw && valid) begin
        model_regs[rows[i].addr[2:0]] = {8'h00, rows[i].wdata};
        write_pending = 1'b1;
      end
      if (rows[i].abort) begin
        timeout_pending = 1'b1;
      end else begin
        model_count = model_count + 1'b1;
        status      = '0;
        status[STAT_ADDR_ERROR]      = !valid;
        status[STAT_WRITE_DONE]      = write_pending;
        status[STAT_TIMEOUT_SEEN]    = timeout_pending;
        status[STAT_ADDR_LSB +: 4]   = rows[i].addr;
        status[STAT_COUNT_LSB +: 16] = model_count;
        rows[i].exp_status = status;
        if (valid) begin
          rows[i].exp_data = model_regs[rows[i].addr[2:0]];
        end else begin
          rows[i].exp_data = '0;
        end
        write_pending   = 1'b0;
        timeout_pending = 1'b0;
      end
    end
  endtask

  // host takes a valid word and closes the four-phase handshake
  task automatic complete_reply;
    host_delay();
    handshake_1 = 1'b1;
    wait_for_handshake_2(1'b0);
    host_delay();
    handshake_1 = 1'b0;
  endtask

  task automatic run_transaction(input int idx);
    row_t row;
    row = rows[idx];
    // idle gap so the FSM sees handshake_1 low before the next command
    repeat (3) @(negedge clk);
    host_delay();
    rw          = row.rw;
    bus_in      = {4'h0, row.addr, row.wdata};
    handshake_1 = 1'b1;
    wait_for_handshake_2(1'b1);
    if (row.abort) begin
      // stall after the command acknowledge until well past the watchdog limit
      wait_for_handshake_2(1'b0);
      repeat (ABORT_HOLD) begin
        @(negedge clk);
        check_value("handshake_2", word_t'(handshake_2), '0);
      end
      handshake_1 = 1'b0;
    end else begin
      host_delay();
      handshake_1 = 1'b0;
      wait_for_handshake_2(1'b0);
      wait_for_handshake_2(1'b1);
      check_value("bus_out data word", bus_out, row.exp_data);
      complete_reply();
      wait_for_handshake_2(1'b1);
      check_value("bus_out status word", bus_out, row.exp_status);
      complete_reply();
    end
  endtask

  initial begin
    clk              = 1'b0;
    reset            = 1'b0;
    subsystem_enable = 1'b0;
    rw               = 1'b0;
    handshake_1      = 1'b0;
    bus_in           = '0;
    cycle_count      = 0;
    row_count        = 0;
    lfsr_state       = 32'h5acd_0dfb;

    // rw, address, write data, abort
    add_row(1'b0, 0,  24'h000000, 1'b0);
    add_row(1'b1, 2,  24'habcdef, 1'b0);
    add_row(1'b0, 2,  24'h000000, 1'b0);
    add_row(1'b1, 7,  24'h123456, 1'b0);
    add_row(1'b0, 9,  24'h000000, 1'b0);
    add_row(1'b1, 12, 24'hffffff, 1'b0);
    add_row(1'b0, 4,  24'h000000, 1'b0);
    add_row(1'b1, 4,  24'h00ff00, 1'b1);
    add_row(1'b0, 4,  24'h000000, 1'b0);
    add_row(1'b1, 0,  24'h5a5a5a, 1'b0);
    add_row(1'b0, 0,  24'h000000, 1'b0);
    add_row(1'b0, 3,  24'h000000, 1'b1);
    add_row(1'b1, 1,  24'h000001, 1'b0);
    add_row(1'b1, 15, 24'h111111, 1'b1);
    add_row(1'b0, 1,  24'h000000, 1'b0);
    add_row(1'b0, 7,  24'h000000, 1'b0);
    compute_expected();

    repeat (16) @(negedge clk);
    reset            = 1'b1;
    subsystem_enable = 1'b1;
    @(negedge clk);
    check_value("handshake_2", word_t'(handshake_2), '0);
    check_value("bus_out", bus_out, '0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_transaction(i);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- bus_subsystem.f
bus_pkg.sv
bus_ctrl_if.sv
bus_fsm.sv
handshake_watchdog.sv
register_bank.sv
reply_formatter.sv
bus_subsystem.sv
tb_bus_subsystem.sv
